// ==== vid_capture_top.f ====
+incdir+.
vid_pkg.sv
vid_mem_if.sv
ycbcr_sampler.sv
ycbcr_to_rgb565.sv
capture_writer.sv
mem_arbiter.sv
frame_ram.sv
smooth_reader.sv
vid_capture_top.sv
tb_vid_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vid_capture \
	-f vid_capture_top.f \
	--Mdir obj_dir

./obj_dir/Vtb_vid_capture > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
exit 0

// ==== tb_vid_tasks.svh ====
// --------------------
// decoder field generator (Cb Y0 Cr Y1 bytes)
// conversion and 3x3 smoothing reference model
// host read and irq helpers, directed tests
// --------------------

	// expected RAM content per bank
	logic [15:0] model [2][vid_pkg::out_width * vid_pkg::out_height];

	task automatic step();
		@(posedge clk_llc);
		#1;	// drive point
	endtask

	// byte source, 0 grey ramp, 1 random, else a slow colour pattern
	function automatic logic [7:0] byte_for(input int src, input int line, input int b);
		int px;
		px = b / 2;
		case (src)
			0: return (b % 2 == 0) ? 8'd128 : 8'(line + px);
			1: return 8'($urandom);
			default:
			begin
				if (b % 4 == 0)
					return 8'(64 + line);	// Cb
				else if (b % 4 == 2)
					return 8'(200 - px / 4);	// Cr
				else
					return 8'(255 - px / 3);
			end
		endcase
	endfunction

	// negative to 0, 2^18 and up to all ones, else the top bits under 18
	function automatic int saturate(input int s, input int bits);
		if (s < 0)
			return 0;
		if (s >= (1 << 18))
			return (1 << bits) - 1;
		return (s >> (18 - bits)) & ((1 << bits) - 1);
	endfunction

	function automatic logic [15:0] rgb_from_ycc(input logic [7:0] y, cb, cr);
		int          ys, cbs, crs, luma;
		logic [15:0] rr, gg, bb;
		ys   = int'(y) * 4 - int'(vid_pkg::y_ofs);	// 10 bit scale
		cbs  = int'(cb) * 4 - int'(vid_pkg::c_ofs);
		crs  = int'(cr) * 4 - int'(vid_pkg::c_ofs);
		luma = int'(vid_pkg::k_y) * ys;
		rr   = 16'(saturate(luma + int'(vid_pkg::k_rv) * crs, 5));
		gg   = 16'(saturate(luma - int'(vid_pkg::k_gv) * crs - int'(vid_pkg::k_gu) * cbs, 6));
		bb   = 16'(saturate(luma + int'(vid_pkg::k_bu) * cbs, 5));
		return {rr[4:0], gg[5:0], bb[4:0]};
	endfunction

	// weights 1-2-1 / 2-4-2 / 1-2-1, then divide by 16
	function automatic logic [15:0] smoothed(input int bank, input int addr);
		int          r, g, b, dr, dc, w, idx;
		logic [15:0] p;
		r = 0;
		g = 0;
		b = 0;
		for (dr = -1; dr <= 1; dr++)
			for (dc = -1; dc <= 1; dc++)
			begin
				w   = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
				idx = (addr + dr * vid_pkg::out_width + dc) & 32'h7fff;	// wrap in bank
				p   = model[bank][idx];
				r  += w * int'(p[15:11]);
				g  += w * int'(p[10:5]);
				b  += w * int'(p[4:0]);
			end
		return {5'(r >> 4), 6'(g >> 4), 5'(b >> 4)};
	endfunction

	// one field, full lines with blanking; model updated for kept pixels
	task automatic send_field(input bit odd_flag, input int src, input int bank);
		int         line, b, px, idx;
		logic [7:0] v, cb, y0;
		odd  = odd_flag;
		vref = 1'b1;
		repeat (porch) step();
		for (line = 0; line < field_lines; line++)
		begin
			for (b = 0; b < 2 * vid_pkg::in_line_pixels; b++)
			begin
				v    = byte_for(src, line, b);
				href = 1'b1;
				vpo  = v;
				px   = (b / 4) * 2;	// Y0 of this group
				case (b % 4)
					0: cb = v;
					1: y0 = v;
					2:
					begin
						if (odd_flag && line % vid_pkg::v_decim == 0 &&
							line / vid_pkg::v_decim < vid_pkg::out_height &&
							px % vid_pkg::h_decim == 0)
						begin
							idx = (line / vid_pkg::v_decim) * vid_pkg::out_width +
								px / vid_pkg::h_decim;
							model[bank][idx] = rgb_from_ycc(y0, cb, v);
						end
					end
					default: ;
				endcase
				step();
			end
			href = 1'b0;
			vpo  = 8'd0;
			repeat (line_gap) step();
		end
		vref = 1'b0;	// closes the field
		repeat (porch) step();
		odd = 1'b0;
	endtask

	// host read handshake, data taken once host_waitx is back high
	task automatic host_read(input bit bank, input int addr, output logic [15:0] data,
		output bit ok);
		int n;
		ok        = 1'b1;
		host_bank = bank;
		host_addr = 15'(addr);
		host_rdx  = 1'b0;
		n         = 0;
		do
		begin
			step();
			n++;
		end
		while (host_waitx && n < rd_limit);
		if (host_waitx)
		begin
			$display("host read bank %0d addr %0d: host_waitx never went low", bank, addr);
			ok = 1'b0;
		end
		n = 0;
		while (!host_waitx && n < rd_limit)
		begin
			step();
			n++;
		end
		if (!host_waitx)
		begin
			$display("host read bank %0d addr %0d: host_waitx stuck low", bank, addr);
			ok = 1'b0;
		end
		data     = host_data;
		host_rdx = 1'b1;
		step();	// strobe high for at least one edge
		if (!ok)
			errors++;
	endtask

	task automatic compare_read(input int bank, input int row, input int col);
		logic [15:0] got, exp;
		bit          ok;
		int          addr;
		addr = row * vid_pkg::out_width + col;
		exp  = smoothed(bank, addr);
		host_read(bank[0], addr, got, ok);
		if (ok)
		begin
			checks++;
			assert (got === exp)
			else
			begin
				$display("[ERROR] t=%0d ns host_data bank %0d row %0d col %0d exp %h got %h",
					$time, bank, row, col, exp, got);
				errors++;
			end
		end
	endtask

	// interior positions only, border reads are undefined
	task automatic check_random_spots(input int bank, input int n);
		int i, r, c;
		for (i = 0; i < n; i++)
		begin
			r = 1 + $urandom % (vid_pkg::out_height - 2);
			c = 1 + $urandom % (vid_pkg::out_width - 2);
			compare_read(bank, r, c);
		end
	endtask

	// irq widths against the counts taken before the field
	task automatic irq_pulse_check(input int c0, c1, want0, want1);
		int n;
		n = 0;
		while (irq0_cycles == c0 && irq1_cycles == c1 && n < 40)
		begin
			step();
			n++;
		end
		repeat (8) step();	// let a pulse finish
		checks += 2;
		assert (irq0_cycles - c0 == want0)
		else
		begin
			$display("[ERROR] t=%0d ns irq0 high cycles exp %0d got %0d",
				$time, want0, irq0_cycles - c0);
			errors++;
		end
		assert (irq1_cycles - c1 == want1)
		else
		begin
			$display("[ERROR] t=%0d ns irq1 high cycles exp %0d got %0d",
				$time, want1, irq1_cycles - c1);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		$display("%s finished, %0d errors", name, errors - err0);
	endtask

	// --------------------
	// directed tests
	// --------------------

	task automatic reset_state_check();
		int err0;
		err0    = errors;
		checks += 3;
		assert (host_waitx === 1'b1)
		else
		begin
			$display("[ERROR] t=%0d ns host_waitx exp 1 got %b", $time, host_waitx);
			errors++;
		end
		assert (irq0 === 1'b0)
		else
		begin
			$display("[ERROR] t=%0d ns irq0 exp 0 got %b", $time, irq0);
			errors++;
		end
		assert (irq1 === 1'b0)
		else
		begin
			$display("[ERROR] t=%0d ns irq1 exp 0 got %b", $time, irq1);
			errors++;
		end
		finish_test("reset values", err0);
	endtask

	task automatic grey_field_capture();
		int err0, c0, c1;
		err0 = errors;
		c0   = irq0_cycles;
		c1   = irq1_cycles;
		send_field(1'b1, 0, 0);	// first field lands in bank 0
		irq_pulse_check(c0, c1, 2, 0);
		compare_read(0, 1, 1);
		compare_read(0, vid_pkg::out_height - 2, vid_pkg::out_width - 2);
		check_random_spots(0, 20);
		finish_test("grey field", err0);
	endtask

	task automatic random_field_capture();
		int err0, c0, c1;
		err0 = errors;
		c0   = irq0_cycles;
		c1   = irq1_cycles;
		send_field(1'b1, 1, 1);	// random bytes hit both clamps
		irq_pulse_check(c0, c1, 0, 2);
		check_random_spots(1, 30);
		finish_test("random colour field", err0);
	endtask

	task automatic bank_retention();
		int err0;
		err0 = errors;
		check_random_spots(0, 16);	// grey field still there
		finish_test("double buffering", err0);
	endtask

	task automatic even_field_skip();
		int err0, c0, c1;
		err0 = errors;
		c0   = irq0_cycles;
		c1   = irq1_cycles;
		send_field(1'b0, 1, 0);	// odd low, nothing captured
		irq_pulse_check(c0, c1, 0, 0);
		check_random_spots(0, 8);
		check_random_spots(1, 8);
		finish_test("even field ignored", err0);
	endtask

	task automatic read_under_capture();
		int err0, c0, c1;
		err0 = errors;
		c0   = irq0_cycles;
		c1   = irq1_cycles;
		fork
			send_field(1'b1, 2, 0);	// new field into bank 0
			begin
				repeat (2 * line_cycles) step();	// reads overlap kept input line 2
				check_random_spots(1, 24);	// bank 1 under write traffic
			end
		join
		irq_pulse_check(c0, c1, 2, 0);
		check_random_spots(0, 8);	// new bank 0 content
		finish_test("read during capture", err0);
	endtask

// ==== tb_vid_capture.sv ====
// --------------------
// testbench top for the video capture design
// clock, reset, DUT instance, irq monitor
// watchdog, test sequence and result line
// --------------------

module tb_vid_capture;

	timeunit 1ns;
	timeprecision 100ps;

	// stimulus geometry
	localparam int line_gap     = 20;	// blanking cycles between lines
	localparam int porch        = 16;	// vref high without href, both ends
	localparam int field_lines  = 2 * vid_pkg::out_height;
	localparam int line_cycles  = 2 * vid_pkg::in_line_pixels + line_gap;
	localparam int field_cycles = field_lines * line_cycles + 2 * porch;
	localparam int rd_limit     = 400;	// cycles per host read phase
	// four fields plus room for all host reads
	localparam int watchdog_ns  = (4 * field_cycles + 50000) * 10;

	logic        clk_llc;
	logic        resetx;
	logic        vref;
	logic        href;
	logic        odd;
	logic [7:0]  vpo;
	logic        host_rdx;
	logic        host_bank;
	logic [14:0] host_addr;
	logic        host_waitx;
	logic [15:0] host_data;
	logic        irq0;
	logic        irq1;

	int          errors      = 0;
	int          checks      = 0;
	int          tests_run   = 0;
	int          irq0_cycles = 0;	// cycles seen high since reset
	int          irq1_cycles = 0;

	vid_capture_top dut0 (
		.clk_llc(clk_llc),
		.resetx(resetx),
		.vref(vref),
		.href(href),
		.odd(odd),
		.vpo(vpo),
		.host_rdx(host_rdx),
		.host_bank(host_bank),
		.host_addr(host_addr),
		.host_waitx(host_waitx),
		.host_data(host_data),
		.irq0(irq0),
		.irq1(irq1)
	);

	`include "tb_vid_tasks.svh"

	// 10 ns clock
	initial
	begin
		clk_llc = 1'b0;
		forever #5 clk_llc = ~clk_llc;
	end

	// irq width monitor, sampled away from the active edge
	always @(negedge clk_llc)
	begin
		if (irq0)
			irq0_cycles++;
		if (irq1)
			irq1_cycles++;
	end

	// ---- watchdog ----
	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, a field or host read is stuck", watchdog_ns);
		$display("Result: FAILED");
		$finish;
	end

	// ---- test sequence ----
	initial
	begin
		void'($urandom(91121));	// one seed for the whole run
		resetx    = 1'b0;
		vref      = 1'b0;
		href      = 1'b0;
		odd       = 1'b0;
		vpo       = 8'd0;
		host_rdx  = 1'b1;	// idle high
		host_bank = 1'b0;
		host_addr = 15'd0;
		repeat (2) @(posedge clk_llc);
		#1;
		resetx = 1'b1;
		step();

		reset_state_check();
		grey_field_capture();
		random_field_capture();
		bank_retention();
		even_field_skip();
		read_under_capture();

		$display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== vid_capture_top.sv ====
// --------------------
// video capture top level
// sampler, converter, writer, arbiter, frame RAM, host reader
// --------------------

module vid_capture_top (
	input  logic        clk_llc,
	input  logic        resetx,
	input  logic        vref,
	input  logic        href,
	input  logic        odd,
	input  logic [7:0]  vpo,
	input  logic        host_rdx,
	input  logic        host_bank,
	input  logic [14:0] host_addr,
	output logic        host_waitx,
	output logic [15:0] host_data,
	output logic        irq0,
	output logic        irq1
);

	vid_pkg::ycc_t     s_ycc;
	logic              s_keep;
	logic              s_field_end;
	logic [6:0]        s_row;
	logic [7:0]        s_col;
	vid_pkg::rgb565_t  c_rgb;
	logic              c_valid;
	logic [6:0]        c_row;
	logic [7:0]        c_col;
	logic [15:0]       ram_addr;
	vid_pkg::rgb565_t  ram_wdata, ram_rdata;
	logic              ram_we, ram_re;

	vid_mem_if vid_wr ();		// capture writer to arbiter
	vid_mem_if host_rd ();		// host reader to arbiter

	ycbcr_sampler u_sampler (
		.clk_llc(clk_llc), .resetx(resetx),
		.vref(vref), .href(href), .odd(odd), .vpo(vpo),
		.ycc(s_ycc), .keep(s_keep), .field_end(s_field_end),
		.row(s_row), .col(s_col)
	);

	ycbcr_to_rgb565 u_conv (
		.clk_llc(clk_llc), .resetx(resetx),
		.ycc(s_ycc), .in_valid(s_keep), .row(s_row), .col(s_col),
		.rgb(c_rgb), .out_valid(c_valid), .row_o(c_row), .col_o(c_col)
	);

	capture_writer u_writer (
		.clk_llc(clk_llc), .resetx(resetx),
		.rgb(c_rgb), .in_valid(c_valid), .row(c_row), .col(c_col),
		.field_end(s_field_end), .mem(vid_wr.client),
		.irq0(irq0), .irq1(irq1)
	);

	mem_arbiter u_arb (
		.clk_llc(clk_llc), .resetx(resetx),
		.vid(vid_wr.arbiter), .host(host_rd.arbiter),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.ram_we(ram_we), .ram_re(ram_re), .ram_rdata(ram_rdata)
	);

	frame_ram u_ram (
		.clk_llc(clk_llc),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.ram_we(ram_we), .ram_re(ram_re), .ram_rdata(ram_rdata)
	);

	smooth_reader u_reader (
		.clk_llc(clk_llc), .resetx(resetx),
		.host_rdx(host_rdx), .host_bank(host_bank), .host_addr(host_addr),
		.host_waitx(host_waitx), .host_data(host_data),
		.mem(host_rd.client)
	);

endmodule

// ==== smooth_reader.sv ====
// --------------------
// host read sequencer
// nine tap 1-2-1 smoothing over the stored frame
// wait generation for the host read strobe
// --------------------

module smooth_reader (
	input  logic                        clk_llc,
	input  logic                        resetx,
	input  logic                        host_rdx,
	input  logic                        host_bank,
	input  logic [vid_pkg::addr_w-1:0]  host_addr,
	output logic                        host_waitx,
	output vid_pkg::rgb565_t            host_data,
	vid_mem_if.client                   mem
);

	vid_pkg::rd_state_t          state;
	logic                        rdx_d;
	logic                        rd_start;	// falling edge of host_rdx
	logic                        req;
	logic                        data_due;	// rdata valid this cycle
	logic                        rd_bank;
	logic [1:0]                  tap_row, tap_col;
	logic [vid_pkg::addr_w-1:0]  tap_addr;
	logic [1:0]                  sh;		// weight 1, 2 or 4
	logic                        last_tap;
	logic [8:0]                  acc_r, acc_b;
	logic [9:0]                  acc_g;

	assign rd_start = (state == vid_pkg::rd_idle) && rdx_d && !host_rdx;
	assign sh       = {1'b0, tap_row == 2'd1} + {1'b0, tap_col == 2'd1};
	assign last_tap = (tap_row == 2'd2) && (tap_col == 2'd2);

	assign mem.req   = req;
	assign mem.addr  = {rd_bank, tap_addr};
	assign mem.wdata = '0;
	assign mem.we    = 1'b0;	// read only client

	// ---- sequencer ----
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			state      <= vid_pkg::rd_idle;
			rdx_d      <= 1'b1;
			host_waitx <= 1'b1;
			req        <= 1'b0;
			data_due   <= 1'b0;
			tap_row    <= 2'd0;
			tap_col    <= 2'd0;
		end
		else
		begin
			rdx_d    <= host_rdx;
			data_due <= req & mem.gnt;
			if (mem.gnt)
				req <= 1'b0;
			case (state)
				vid_pkg::rd_idle:
				begin
					if (rd_start)
					begin
						state      <= vid_pkg::rd_fetch;
						host_waitx <= 1'b0;
						req        <= 1'b1;
						tap_row    <= 2'd0;
						tap_col    <= 2'd0;
					end
				end
				vid_pkg::rd_fetch:
				begin
					if (data_due && last_tap)
						state <= vid_pkg::rd_done;
					else if (data_due)
					begin
						req <= 1'b1;	// next tap
						if (tap_col == 2'd2)
						begin
							tap_col <= 2'd0;
							tap_row <= tap_row + 2'd1;
						end
						else
							tap_col <= tap_col + 2'd1;
					end
				end
				vid_pkg::rd_done:
				begin
					state      <= vid_pkg::rd_idle;
					host_waitx <= 1'b1;	// host_data valid from here
				end
				default:
					state <= vid_pkg::rd_idle;
			endcase
		end
	end

	// ---- tap address and accumulators ----
	always_ff @(posedge clk_llc)
	begin
		if (rd_start)
		begin
			rd_bank  <= host_bank;
			tap_addr <= vid_pkg::addr_w'(host_addr - (vid_pkg::out_width + 1));
			acc_r    <= 9'd0;
			acc_g    <= 10'd0;
			acc_b    <= 9'd0;
		end
		else if (state == vid_pkg::rd_fetch && data_due)
		begin
			acc_r <= acc_r + (9'(mem.rdata.r) << sh);
			acc_g <= acc_g + (10'(mem.rdata.g) << sh);
			acc_b <= acc_b + (9'(mem.rdata.b) << sh);
			if (tap_col == 2'd2)
				tap_addr <= vid_pkg::addr_w'(tap_addr + vid_pkg::out_width - 2);
			else
				tap_addr <= tap_addr + 1'b1;	// wraps in the bank
		end
		if (state == vid_pkg::rd_done)
		begin
			host_data.r <= acc_r[8:4];	// divide by 16
			host_data.g <= acc_g[9:4];
			host_data.b <= acc_b[8:4];
		end
	end

endmodule

// ==== frame_ram.sv ====
// --------------------
// two bank frame memory, one word per pixel
// single port, registered read
// --------------------

module frame_ram (
	input  logic              clk_llc,
	input  logic [15:0]       ram_addr,
	input  vid_pkg::rgb565_t  ram_wdata,
	input  logic              ram_we,
	input  logic              ram_re,
	output vid_pkg::rgb565_t  ram_rdata
);

	vid_pkg::rgb565_t mem [2 * vid_pkg::out_width * vid_pkg::out_height];

	logic        in_range;	// pixel index inside the picture
	logic [15:0] ofs;

	// bank 1 packed straight after bank 0
	always_comb
	begin
		in_range = ram_addr[14:0] < vid_pkg::out_width * vid_pkg::out_height;
		ofs      = {1'b0, ram_addr[14:0]} +
			(ram_addr[15] ? 16'(vid_pkg::out_width * vid_pkg::out_height) : 16'd0);
	end

	always_ff @(posedge clk_llc)
	begin
		if (ram_we && in_range)
			mem[ofs] <= ram_wdata;
		if (ram_re)
			ram_rdata <= in_range ? mem[ofs] : '0;	// reserved area reads 0
	end

endmodule

// ==== mem_arbiter.sv ====
// --------------------
// single RAM port arbiter
// video writes first, host reads otherwise
// --------------------

module mem_arbiter (
	input  logic              clk_llc,
	input  logic              resetx,
	vid_mem_if.arbiter        vid,
	vid_mem_if.arbiter        host,
	output logic [15:0]       ram_addr,
	output vid_pkg::rgb565_t  ram_wdata,
	output logic              ram_we,
	output logic              ram_re,
	input  vid_pkg::rgb565_t  ram_rdata
);

	vid_pkg::arb_state_t state, next_state;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			state <= vid_pkg::arb_idle;
		else
			state <= next_state;
	end

	// one access per grant, always back through idle
	always_comb
	begin
		next_state = vid_pkg::arb_idle;
		if (state == vid_pkg::arb_idle)
		begin
			if (vid.req)
				next_state = vid_pkg::arb_vid_write;
			else if (host.req)
				next_state = vid_pkg::arb_host_read;
		end
	end

	// RAM controls follow the granted client
	always_comb
	begin
		vid.gnt   = 1'b0;
		host.gnt  = 1'b0;
		ram_addr  = host.addr;
		ram_wdata = host.wdata;
		ram_we    = 1'b0;
		ram_re    = 1'b0;
		case (state)
			vid_pkg::arb_vid_write:
			begin
				vid.gnt   = 1'b1;
				ram_addr  = vid.addr;
				ram_wdata = vid.wdata;
				ram_we    = vid.we;
			end
			vid_pkg::arb_host_read:
			begin
				host.gnt = 1'b1;
				ram_we   = host.we;
				ram_re   = ~host.we;
			end
			default:
			begin
				ram_we = 1'b0;	// idle
			end
		endcase
	end

	assign host.rdata = ram_rdata;
	assign vid.rdata  = ram_rdata;

endmodule

// ==== capture_writer.sv ====
// --------------------
// bank word address from row and column
// one pending pixel held until the RAM grant
// bank toggle and 2 cycle frame interrupts
// --------------------

module capture_writer (
	input  logic              clk_llc,
	input  logic              resetx,
	input  vid_pkg::rgb565_t  rgb,
	input  logic              in_valid,
	input  logic [6:0]        row,
	input  logic [7:0]        col,
	input  logic              field_end,
	vid_mem_if.client         mem,
	output logic              irq0,
	output logic              irq1
);

	logic                        bank;		// bank being filled
	logic                        pend;		// pixel waiting for gnt
	logic [15:0]                 pend_addr;
	vid_pkg::rgb565_t            pend_data;
	logic [vid_pkg::addr_w-1:0]  idx;
	logic [1:0]                  irq_cnt;
	logic                        irq_bank;	// bank that just finished

	assign idx = vid_pkg::addr_w'(row * vid_pkg::out_width + col);

	assign mem.req   = pend;
	assign mem.addr  = pend_addr;
	assign mem.wdata = pend_data;
	assign mem.we    = 1'b1;	// write only client

	assign irq0 = (irq_cnt != 2'd0) && !irq_bank;
	assign irq1 = (irq_cnt != 2'd0) && irq_bank;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			pend     <= 1'b0;
			bank     <= 1'b0;	// first field to bank 0
			irq_cnt  <= 2'd0;
			irq_bank <= 1'b0;
		end
		else
		begin
			if (in_valid)
				pend <= 1'b1;	// new pixel wins over a grant
			else if (mem.gnt)
				pend <= 1'b0;

			if (field_end)
			begin
				bank     <= ~bank;
				irq_bank <= bank;
				irq_cnt  <= 2'd2;
			end
			else if (irq_cnt != 2'd0)
				irq_cnt <= irq_cnt - 2'd1;
		end
	end

	// address fixed at load time so a late write keeps its bank
	always_ff @(posedge clk_llc)
	begin
		if (in_valid)
		begin
			pend_addr <= (bank ? vid_pkg::bank_base : 16'h0000) | {1'b0, idx};
			pend_data <= rgb;
		end
	end

endmodule

// ==== ycbcr_to_rgb565.sv ====
// --------------------
// YCbCr to RGB565 conversion, two stages
// stage 1 coefficient products, stage 2 sums and clamp
// row and column tags ride along with the pixel
// --------------------

module ycbcr_to_rgb565 (
	input  logic              clk_llc,
	input  logic              resetx,
	input  vid_pkg::ycc_t     ycc,
	input  logic              in_valid,
	input  logic [6:0]        row,
	input  logic [7:0]        col,
	output vid_pkg::rgb565_t  rgb,
	output logic              out_valid,
	output logic [6:0]        row_o,
	output logic [7:0]        col_o
);

	logic signed [10:0] y_s, cb_s, cr_s;	// offset removed, 10 bit scale
	logic signed [20:0] p_y, p_rv, p_gv, p_gu, p_bu;
	logic signed [20:0] r_sum, g_sum, b_sum;
	logic [5:0]         r6, g6, b6;
	logic               v1;
	logic [6:0]         row1;
	logic [7:0]         col1;

	// negative to 0, overflow to all ones, else bits 17..12
	function automatic logic [5:0] clamp6(input logic signed [20:0] s);
		if (s[20])
			return 6'd0;
		else if (s[19] | s[18])
			return 6'h3f;
		else
			return s[17:12];
	endfunction

	always_comb
	begin
		y_s  = $signed({1'b0, ycc.y, 2'b00}) - $signed({1'b0, vid_pkg::y_ofs});
		cb_s = $signed({1'b0, ycc.cb, 2'b00}) - $signed({1'b0, vid_pkg::c_ofs});
		cr_s = $signed({1'b0, ycc.cr, 2'b00}) - $signed({1'b0, vid_pkg::c_ofs});
	end

	// ---- stage 1 ----
	always_ff @(posedge clk_llc)
	begin
		p_y  <= y_s * $signed({1'b0, vid_pkg::k_y});
		p_rv <= cr_s * $signed({1'b0, vid_pkg::k_rv});
		p_gv <= cr_s * $signed({1'b0, vid_pkg::k_gv});
		p_gu <= cb_s * $signed({1'b0, vid_pkg::k_gu});
		p_bu <= cb_s * $signed({1'b0, vid_pkg::k_bu});
		row1 <= row;
		col1 <= col;
	end

	// ---- stage 2 ----
	always_comb
	begin
		r_sum = p_y + p_rv;
		g_sum = p_y - p_gv - p_gu;
		b_sum = p_y + p_bu;
		r6    = clamp6(r_sum);	// R and B keep the top five
		g6    = clamp6(g_sum);
		b6    = clamp6(b_sum);
	end

	always_ff @(posedge clk_llc)
	begin
		rgb.r <= r6[5:1];
		rgb.g <= g6;
		rgb.b <= b6[5:1];
		row_o <= row1;
		col_o <= col1;
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			v1        <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			v1        <= in_valid;
			out_valid <= v1;
		end
	end

endmodule

// ==== ycbcr_sampler.sv ====
// --------------------
// decoder byte stream demux (Cb Y0 Cr Y1)
// field and line tracking
// decimation keep strobe with row and column
// --------------------

module ycbcr_sampler (
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              vref,
	input  logic              href,
	input  logic              odd,
	input  logic [7:0]        vpo,
	output vid_pkg::ycc_t     ycc,
	output logic              keep,
	output logic              field_end,
	output logic [6:0]        row,
	output logic [7:0]        col
);

	logic       cap;		// odd field and vref both high
	logic       active;		// byte on vpo this cycle
	logic       cap_d;
	logic       href_d;
	logic [1:0] phase;		// byte position in the group of four
	logic [8:0] grp;		// group index in the line
	logic [8:0] line_cnt;		// lines since the first href of the field
	logic       line_keep;
	logic       take;
	logic [7:0] cb_q;
	logic [7:0] y_q;

	assign cap    = odd & vref;
	assign active = cap & href;

	// even lines only, up to out_height of them
	assign line_keep = (line_cnt % vid_pkg::v_decim == 0) &&
		(line_cnt / vid_pkg::v_decim < vid_pkg::out_height);

	// Y0 of every other group, taken when its Cr shows up
	assign take = active && (phase == 2'd2) && line_keep &&
		((grp * 2) % vid_pkg::h_decim == 0) && (grp < vid_pkg::in_line_pixels / 2);

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			cap_d     <= 1'b0;
			href_d    <= 1'b0;
			phase     <= 2'd0;
			grp       <= 9'd0;
			line_cnt  <= 9'd0;
			keep      <= 1'b0;
			field_end <= 1'b0;
		end
		else
		begin
			cap_d     <= cap;
			href_d    <= active;
			keep      <= take;
			field_end <= cap_d & ~cap;	// captured field just closed

			if (active)
			begin
				phase <= phase + 2'd1;
				if (phase == 2'd3)
					grp <= grp + 9'd1;
			end
			else
			begin
				phase <= 2'd0;		// realign on every line
				grp   <= 9'd0;
			end

			if (!cap)
				line_cnt <= 9'd0;
			else if (href_d && !href)
				line_cnt <= line_cnt + 9'd1;	// end of a line
		end
	end

	// chroma pair and luma bytes
	always_ff @(posedge clk_llc)
	begin
		if (active && phase == 2'd0)
			cb_q <= vpo;
		if (active && phase == 2'd1)
			y_q <= vpo;
		if (take)
		begin
			ycc.y  <= y_q;
			ycc.cb <= cb_q;
			ycc.cr <= vpo;
			row    <= 7'(line_cnt / vid_pkg::v_decim);
			col    <= 8'(grp * 2 / vid_pkg::h_decim);
		end
	end

endmodule

// ==== vid_mem_if.sv ====
// --------------------
// one client port onto the shared frame RAM
// client and arbiter views
// --------------------

interface vid_mem_if;

	logic              req;	// held until gnt
	logic [15:0]       addr;	// bank bit on top
	vid_pkg::rgb565_t  wdata;
	logic              we;
	logic              gnt;	// one cycle per access
	vid_pkg::rgb565_t  rdata;	// valid the cycle after gnt on a read

	modport client (
		output req,
		output addr,
		output wdata,
		output we,
		input  gnt,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  addr,
		input  wdata,
		input  we,
		output gnt,
		output rdata
	);

endinterface

// ==== vid_pkg.sv ====
// --------------------
// geometry of the captured picture and the bank layout
// Q2.8 colour conversion constants and offsets
// pixel types and state enums shared by the capture path
// --------------------

package vid_pkg;

	// input and stored picture size
	localparam int in_line_pixels = 720;	// active pixels per decoder line
	localparam int out_width      = 180;
	localparam int out_height     = 120;
	localparam int h_decim        = 4;	// keep one pixel in four
	localparam int v_decim        = 2;	// keep one line in two

	localparam logic [15:0] bank_base = 16'h8000;	// word offset of bank 1
	localparam int          addr_w    = 15;		// pixel index inside a bank

	// conversion coefficients, Q2.8
	localparam logic [9:0] k_y  = 10'b01_0010_1010;	// 1.164
	localparam logic [9:0] k_rv = 10'b01_1001_1001;	// 1.596
	localparam logic [9:0] k_gv = 10'b00_1101_0000;	// 0.813
	localparam logic [9:0] k_gu = 10'b00_0110_0100;	// 0.392
	localparam logic [9:0] k_bu = 10'b10_0000_0100;	// 2.017

	localparam logic [9:0] y_ofs = 10'd64;	// 10 bit scale
	localparam logic [9:0] c_ofs = 10'd512;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic [7:0] y;
		logic [7:0] cb;
		logic [7:0] cr;
	} ycc_t;

	typedef enum logic [1:0] {arb_idle, arb_vid_write, arb_host_read} arb_state_t;
	typedef enum logic [1:0] {rd_idle, rd_fetch, rd_done} rd_state_t;

endpackage
